/* hw/noc_cfg_pkg.sv */
// ########################################
// sizing constants of the packet switch
// every block reads these by scoped name
// ########################################

`default_nettype none

package noc_cfg_pkg;

  // input and output ports of the switch
  localparam int NumPorts = 4;

  // bits needed to name one port
  localparam int PortIdWidth = 2;

  // data bits carried by one flit
  localparam int PayloadWidth = 32;

endpackage

`default_nettype wire

/* hw/noc_flit_pkg.sv */
// ########################################
// flit and port vector types shared by
// the decoder, output ports and collector
// ########################################

`default_nettype none

package noc_flit_pkg;

  // one bit per port for request, grant and accept vectors
  typedef logic [noc_cfg_pkg::NumPorts-1:0] port_vec_t;

  // index of one port
  typedef logic [noc_cfg_pkg::PortIdWidth-1:0] port_id_t;

  // single flit as it moves through the switch
  typedef struct packed {
    logic [noc_cfg_pkg::PortIdWidth-1:0]  dst;
    logic [noc_cfg_pkg::PayloadWidth-1:0] payload;
    logic                                 last;
  } flit_t;

  // one flit per port, indexed by port number
  typedef flit_t [noc_cfg_pkg::NumPorts-1:0] in_flits_t;

endpackage

`default_nettype wire

/* hw/rr_arbiter.sv */
// ########################################
// round-robin arbiter with one-hot and
// index grant; the search start advances
// only when update_i is pulsed
// ########################################

`default_nettype none

module rr_arbiter (
  input  logic                    clk_i,
  input  logic                    rst_n_i,
  input  noc_flit_pkg::port_vec_t req_i,
  input  logic                    update_i,
  output noc_flit_pkg::port_vec_t grant_o,
  output noc_flit_pkg::port_id_t  grant_id_o
);

  noc_flit_pkg::port_id_t               ptr_q;
  noc_flit_pkg::port_id_t               ptr_d;
  logic [2*noc_cfg_pkg::NumPorts-1:0]   rot_req_wide;
  noc_flit_pkg::port_vec_t              rot_req;
  noc_flit_pkg::port_vec_t              rot_sel;
  logic [2*noc_cfg_pkg::NumPorts-1:0]   rot_back_wide;

  // rotate right so that the start position lands on bit 0
  assign rot_req_wide = {req_i, req_i} >> ptr_q;
  assign rot_req      = rot_req_wide[noc_cfg_pkg::NumPorts-1:0];

  // keep only the lowest set bit
  assign rot_sel = rot_req & (~rot_req + 1'b1);

  // rotate back by the same amount
  assign rot_back_wide = {rot_sel, rot_sel} << ptr_q;
  assign grant_o       = rot_back_wide[2*noc_cfg_pkg::NumPorts-1:noc_cfg_pkg::NumPorts];

  // index bit b collects every grant position whose number has bit b set
  for (genvar b = 0; b < noc_cfg_pkg::PortIdWidth; b++) begin : gen_id_bit
    noc_flit_pkg::port_vec_t id_mask;
    for (genvar j = 0; j < noc_cfg_pkg::NumPorts; j++) begin : gen_id_mask
      assign id_mask[j] = ((j >> b) % 2) == 1;
    end
    assign grant_id_o[b] = |(grant_o & id_mask);
  end

  // next search starts just after the input served, with wrap
  assign ptr_d = (grant_id_o == noc_flit_pkg::port_id_t'(noc_cfg_pkg::NumPorts - 1)) ?
                 '0 : grant_id_o + 1'b1;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      ptr_q <= '0;
    end else if (update_i) begin
      ptr_q <= ptr_d;
    end
  end

  // at most one grant, and some grant whenever anyone asks
  property p_grant_shape;
    @(posedge clk_i) disable iff (!rst_n_i)
      $onehot0(grant_o) && ((req_i == '0) || $onehot(grant_o));
  endproperty

  a_grant_shape: assert property (p_grant_shape)
    else $error("arbiter grant %b does not fit requests %b", grant_o, req_i);

endmodule

`default_nettype wire

/* hw/route_decode.sv */
// ########################################
// turns the dst of every valid input flit
// into one request vector per output
// ########################################

`default_nettype none

module route_decode (
  input  noc_flit_pkg::in_flits_t                           in_flit_i,
  input  noc_flit_pkg::port_vec_t                           in_valid_i,
  output noc_flit_pkg::port_vec_t [noc_cfg_pkg::NumPorts-1:0] req_matrix_o
);

  // row k holds the one-hot destination of input k
  noc_flit_pkg::port_vec_t [noc_cfg_pkg::NumPorts-1:0] dst_hot;

  always_comb begin
    for (int k = 0; k < noc_cfg_pkg::NumPorts; k++) begin
      for (int j = 0; j < noc_cfg_pkg::NumPorts; j++) begin
        dst_hot[k][j] = in_valid_i[k] && (in_flit_i[k].dst == j);
      end
    end
  end

  // transpose so each output sees one bit per input
  always_comb begin
    for (int j = 0; j < noc_cfg_pkg::NumPorts; j++) begin
      for (int k = 0; k < noc_cfg_pkg::NumPorts; k++) begin
        req_matrix_o[j][k] = dst_hot[k][j];
      end
    end
  end

  // read the columns of the transposed matrix back
  always_comb begin
    for (int k = 0; k < noc_cfg_pkg::NumPorts; k++) begin
      noc_flit_pkg::port_vec_t col;
      for (int j = 0; j < noc_cfg_pkg::NumPorts; j++) begin
        col[j] = req_matrix_o[j][k];
      end
      a_one_dst: assert final (!in_valid_i[k] || $onehot(col))
        else $error("input %0d requests outputs %b", k, col);
    end
  end

endmodule

`default_nettype wire

/* hw/output_port.sv */
// ########################################
// one output of the switch; picks an input
// round robin, holds it for a whole packet
// and registers the chosen flit
// ########################################

`default_nettype none

module output_port (
  input  logic                    clk_i,
  input  logic                    rst_n_i,
  input  noc_flit_pkg::port_vec_t req_i,
  input  noc_flit_pkg::in_flits_t in_flit_i,
  output noc_flit_pkg::port_vec_t grant_o,
  output logic                    out_valid_o,
  output noc_flit_pkg::flit_t     out_flit_o
);

  logic                    lock_q;
  noc_flit_pkg::port_id_t  lock_id_q;
  noc_flit_pkg::port_vec_t lock_mask;
  noc_flit_pkg::port_vec_t arb_req;
  noc_flit_pkg::port_id_t  grant_id;
  noc_flit_pkg::flit_t     sel_flit;
  logic                    granted;
  logic                    last_granted;
  logic                    out_valid_q;
  noc_flit_pkg::flit_t     out_flit_q;

  // while a packet is open only its input may compete
  assign lock_mask = noc_flit_pkg::port_vec_t'(1) << lock_id_q;
  assign arb_req   = lock_q ? (req_i & lock_mask) : req_i;

  rr_arbiter i_rr_arbiter (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .req_i      (arb_req),
    .update_i   (last_granted),
    .grant_o    (grant_o),
    .grant_id_o (grant_id)
  );

  assign granted      = |grant_o;
  assign sel_flit     = in_flit_i[grant_id];
  // the round moves on only when a packet closes
  assign last_granted = granted && sel_flit.last;

  // packet lock
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      lock_q    <= 1'b0;
      lock_id_q <= '0;
    end else if (granted) begin
      if (sel_flit.last) begin
        lock_q <= 1'b0;
      end else begin
        lock_q    <= 1'b1;
        lock_id_q <= grant_id;
      end
    end
  end

  // one-cycle valid strobe after every grant
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      out_valid_q <= 1'b0;
    end else begin
      out_valid_q <= granted;
    end
  end

  always_ff @(posedge clk_i) begin
    if (granted) begin
      out_flit_q <= sel_flit;
    end
  end

  assign out_valid_o = out_valid_q;
  assign out_flit_o  = out_flit_q;

  // an open packet keeps the output to itself
  property p_lock_hold;
    @(posedge clk_i) disable iff (!rst_n_i)
      lock_q |-> ((grant_o & ~lock_mask) == '0);
  endproperty

  a_lock_hold: assert property (p_lock_hold)
    else $error("grant %b while locked to input %0d", grant_o, lock_id_q);

endmodule

`default_nettype wire

/* hw/grant_collect.sv */
// ########################################
// folds the grants of all outputs into
// one accept strobe per input
// ########################################

`default_nettype none

module grant_collect (
  input  noc_flit_pkg::port_vec_t [noc_cfg_pkg::NumPorts-1:0] grant_matrix_i,
  output noc_flit_pkg::port_vec_t                           in_accept_o
);

  // input k is accepted if any output grants it
  always_comb begin
    in_accept_o = '0;
    for (int j = 0; j < noc_cfg_pkg::NumPorts; j++) begin
      in_accept_o = in_accept_o | grant_matrix_i[j];
    end
  end

  // one input feeds at most one output per cycle
  always_comb begin
    for (int k = 0; k < noc_cfg_pkg::NumPorts; k++) begin
      noc_flit_pkg::port_vec_t col;
      for (int j = 0; j < noc_cfg_pkg::NumPorts; j++) begin
        col[j] = grant_matrix_i[j][k];
      end
      a_single_owner: assert final ($onehot0(col))
        else $error("input %0d granted by outputs %b", k, col);
    end
  end

endmodule

`default_nettype wire

/* hw/noc_switch.sv */
// ########################################
// four-port packet switch top level
// inputs hold a flit until accepted and
// outputs strobe one cycle later
// ########################################

`default_nettype none

module noc_switch (
  input  logic                    clk_i,
  input  logic                    rst_n_i,
  input  noc_flit_pkg::port_vec_t in_valid_i,
  input  noc_flit_pkg::in_flits_t in_flit_i,
  output noc_flit_pkg::port_vec_t in_accept_o,
  output noc_flit_pkg::port_vec_t out_valid_o,
  output noc_flit_pkg::in_flits_t out_flit_o
);

  // row j belongs to output j, bit k to input k
  noc_flit_pkg::port_vec_t [noc_cfg_pkg::NumPorts-1:0] req_matrix;
  noc_flit_pkg::port_vec_t [noc_cfg_pkg::NumPorts-1:0] grant_matrix;

  route_decode i_route_decode (
    .in_flit_i    (in_flit_i),
    .in_valid_i   (in_valid_i),
    .req_matrix_o (req_matrix)
  );

  // every output sees all input flits
  for (genvar j = 0; j < noc_cfg_pkg::NumPorts; j++) begin : gen_out
    output_port i_output_port (
      .clk_i       (clk_i),
      .rst_n_i     (rst_n_i),
      .req_i       (req_matrix[j]),
      .in_flit_i   (in_flit_i),
      .grant_o     (grant_matrix[j]),
      .out_valid_o (out_valid_o[j]),
      .out_flit_o  (out_flit_o[j])
    );
  end

  grant_collect i_grant_collect (
    .grant_matrix_i (grant_matrix),
    .in_accept_o    (in_accept_o)
  );

endmodule

`default_nettype wire

/* testbench/clk_gen.sv */
// ########################################
// clock and reset source of the testbench
// 10 unit period, reset low for 16 cycles
// ########################################

`default_nettype none

module clk_gen (
  output logic clk_o,
  output logic rst_n_o
);

  localparam int HalfPeriod  = 5;
  localparam int ResetCycles = 16;

  initial begin
    clk_o = 1'b0;
    forever #HalfPeriod clk_o = ~clk_o;
  end

  // release just after an edge so the async reset never races the clock
  initial begin
    rst_n_o = 1'b0;
    repeat (ResetCycles) @(posedge clk_o);
    #1 rst_n_o = 1'b1;
  end

endmodule

`default_nettype wire

/* testbench/tb_noc_switch.sv */
// ########################################
// testbench of the packet switch; reads the
// cases file, drives every input and checks
// routing, order, packets and fairness
// ########################################

`default_nettype none

module tb_noc_switch;

  localparam int MaxFlits   = 32;
  localparam int CaseWords  = 5 * 64;
  localparam int NumPairs   = noc_cfg_pkg::NumPorts * noc_cfg_pkg::NumPorts;
  localparam int NumPhases  = 3;
  localparam int DriveDelay = 1;

  logic                    clk;
  logic                    rst_n;
  noc_flit_pkg::port_vec_t in_valid;
  noc_flit_pkg::in_flits_t in_flit;
  noc_flit_pkg::port_vec_t in_accept;
  noc_flit_pkg::port_vec_t out_valid;
  noc_flit_pkg::in_flits_t out_flit;

  // five words of the cases file per flit
  logic [31:0]             case_mem [0:CaseWords-1];
  // per-input packet lists in file order
  noc_flit_pkg::flit_t     in_mem [noc_cfg_pkg::NumPorts][MaxFlits];
  int                      in_ph [noc_cfg_pkg::NumPorts][MaxFlits];
  int                      in_cnt [noc_cfg_pkg::NumPorts];
  // expected flits in one list per input and output pair
  noc_flit_pkg::flit_t     exp_mem [NumPairs][MaxFlits];
  int                      exp_ph [NumPairs][MaxFlits];
  int                      exp_wr [NumPairs];
  int                      exp_rd [NumPairs];
  int                      phase_total [NumPhases+1];
  int                      recv_cnt [NumPhases+1];
  int                      total_flits;
  int                      cur_phase;
  int                      value_errs;
  int                      misc_errs;
  int                      cycle_cnt;
  int                      timeout_limit;
  noc_flit_pkg::port_vec_t exp_valid_q;
  noc_flit_pkg::port_vec_t open_pkt;
  noc_flit_pkg::port_id_t  open_src [noc_cfg_pkg::NumPorts];
  noc_flit_pkg::port_id_t  fair_next;
  logic                    par_seen;

  clk_gen i_clk_gen (
    .clk_o   (clk),
    .rst_n_o (rst_n)
  );

  noc_switch i_dut (
    .clk_i       (clk),
    .rst_n_i     (rst_n),
    .in_valid_i  (in_valid),
    .in_flit_i   (in_flit),
    .in_accept_o (in_accept),
    .out_valid_o (out_valid),
    .out_flit_o  (out_flit)
  );

  task automatic check_flit(input string name, input noc_flit_pkg::flit_t exp_f,
                            input noc_flit_pkg::flit_t act_f);
    if (act_f !== exp_f) begin
      value_errs++;
      $display("ERROR t=%0t %s: expected dst %0d payload %h last %b, got dst %0d payload %h last %b",
               $time, name, exp_f.dst, exp_f.payload, exp_f.last,
               act_f.dst, act_f.payload, act_f.last);
    end
  endtask

  task automatic check_port_id(input string name, input noc_flit_pkg::port_id_t exp_id,
                               input noc_flit_pkg::port_id_t act_id);
    if (act_id !== exp_id) begin
      value_errs++;
      $display("ERROR t=%0t %s: expected %0d, got %0d", $time, name, exp_id, act_id);
    end
  endtask

  task automatic check_valid(input string name, input logic exp_v, input logic act_v);
    if (act_v !== exp_v) begin
      value_errs++;
      $display("ERROR t=%0t %s: expected %b, got %b", $time, name, exp_v, act_v);
    end
  endtask

  task automatic load_cases();
    int                  idx;
    int                  ph;
    int                  src;
    int                  dst;
    int                  pair;
    logic                done;
    noc_flit_pkg::flit_t f;
    $readmemh("testbench/switch_cases.txt", case_mem);
    idx  = 0;
    done = 1'b0;
    while (!done) begin
      if (idx + 5 > CaseWords || $isunknown(case_mem[idx])) begin
        misc_errs++;
        $display("cases file is missing or has no end marker");
        done = 1'b1;
      end else if (case_mem[idx] == 32'hf) begin
        done = 1'b1;
      end else begin
        ph  = case_mem[idx];
        src = case_mem[idx+1];
        dst = case_mem[idx+2];
        if (ph < 1 || ph > NumPhases || src >= noc_cfg_pkg::NumPorts ||
            dst >= noc_cfg_pkg::NumPorts) begin
          misc_errs++;
          $display("cases file has a bad line at word %0d", idx);
        end else begin
          f.dst     = noc_flit_pkg::port_id_t'(dst);
          f.payload = case_mem[idx+3];
          f.last    = case_mem[idx+4][0];
          in_mem[src][in_cnt[src]] = f;
          in_ph[src][in_cnt[src]]  = ph;
          in_cnt[src]++;
          pair = src * noc_cfg_pkg::NumPorts + dst;
          exp_mem[pair][exp_wr[pair]] = f;
          exp_ph[pair][exp_wr[pair]]  = ph;
          exp_wr[pair]++;
          phase_total[ph]++;
          total_flits++;
        end
        idx += 5;
      end
    end
  endtask

  // holds each flit until its accept edge and then moves on to the next one
  task automatic drive_input(input int k);
    int i;
    int gap;
    wait (rst_n === 1'b1);
    @(posedge clk);
    #DriveDelay;
    for (i = 0; i < in_cnt[k]; i++) begin
      while (cur_phase < in_ph[k][i]) begin
        @(posedge clk);
        #DriveDelay;
      end
      gap = (in_ph[k][i] == 3) ? int'($urandom % 3) : 0;
      repeat (gap) begin
        @(posedge clk);
        #DriveDelay;
      end
      in_valid[k] = 1'b1;
      in_flit[k]  = in_mem[k][i];
      @(negedge clk);
      while (in_accept[k] !== 1'b1) @(negedge clk);
      @(posedge clk);
      #DriveDelay;
      in_valid[k] = 1'b0;
    end
  endtask

  task automatic take_flit(input int j);
    noc_flit_pkg::flit_t    f;
    noc_flit_pkg::port_id_t src;
    int                     pair;
    int                     ph;
    f = out_flit[j];
    // the top hex digit of the payload names the sending input
    src  = noc_flit_pkg::port_id_t'(f.payload >> (noc_cfg_pkg::PayloadWidth - 4));
    pair = src * noc_cfg_pkg::NumPorts + j;
    if (open_pkt[j]) begin
      check_port_id($sformatf("source on out_flit_o[%0d]", j), open_src[j], src);
    end
    if (exp_rd[pair] >= exp_wr[pair]) begin
      misc_errs++;
      $display("output %0d carried a flit from input %0d that was never sent to it, at %0t",
               j, src, $time);
    end else begin
      ph = exp_ph[pair][exp_rd[pair]];
      check_flit($sformatf("out_flit_o[%0d]", j), exp_mem[pair][exp_rd[pair]], f);
      if (ph == 1) begin
        check_port_id("round-robin source of out_flit_o[0]", fair_next, src);
        fair_next = fair_next + 1'b1;
      end
      if (ph == 2) begin
        par_seen = 1'b1;
      end
      recv_cnt[ph]++;
      exp_rd[pair]++;
    end
    open_pkt[j] = !f.last;
    open_src[j] = src;
  endtask

  // outputs strobe exactly one cycle after an accept toward them
  task automatic sample_cycle();
    noc_flit_pkg::port_vec_t nxt;
    int                      j;
    int                      k;
    nxt      = '0;
    par_seen = 1'b0;
    for (j = 0; j < noc_cfg_pkg::NumPorts; j++) begin
      check_valid($sformatf("out_valid_o[%0d]", j), exp_valid_q[j], out_valid[j]);
    end
    for (j = 0; j < noc_cfg_pkg::NumPorts; j++) begin
      if (out_valid[j] === 1'b1) begin
        take_flit(j);
      end
    end
    if (par_seen) begin
      for (j = 0; j < noc_cfg_pkg::NumPorts; j++) begin
        check_valid($sformatf("out_valid_o[%0d] in parallel phase", j), 1'b1, out_valid[j]);
      end
    end
    for (k = 0; k < noc_cfg_pkg::NumPorts; k++) begin
      if (in_accept[k] === 1'b1) begin
        if (in_valid[k] !== 1'b1) begin
          misc_errs++;
          $display("input %0d was accepted while it offered no flit, at %0t", k, $time);
        end else begin
          nxt[in_flit[k].dst] = 1'b1;
        end
      end
    end
    exp_valid_q = nxt;
  endtask

  // monitoring starts with the first cycle out of reset
  always @(negedge clk) begin
    if (rst_n === 1'b1) begin
      sample_cycle();
    end
  end

  always @(posedge clk) begin
    cycle_cnt++;
    if (cycle_cnt > timeout_limit) begin
      $display("run stopped after %0d cycles with packets still in flight", cycle_cnt);
      $display("value errors %0d, other errors %0d", value_errs, misc_errs);
      $display("Simulation FAILED");
      $finish;
    end
  end

  initial begin
    int p;
    int pair;
    void'($urandom(32'h29e23398));
    in_valid    = '0;
    in_flit     = '0;
    exp_valid_q = '0;
    open_pkt    = '0;
    fair_next   = '0;
    par_seen    = 1'b0;
    cur_phase   = 0;
    value_errs  = 0;
    misc_errs   = 0;
    cycle_cnt   = 0;
    total_flits = 0;
    timeout_limit = 200;
    for (p = 0; p < noc_cfg_pkg::NumPorts; p++) begin
      in_cnt[p]   = 0;
      open_src[p] = '0;
    end
    for (pair = 0; pair < NumPairs; pair++) begin
      exp_wr[pair] = 0;
      exp_rd[pair] = 0;
    end
    for (p = 0; p <= NumPhases; p++) begin
      phase_total[p] = 0;
      recv_cnt[p]    = 0;
    end
    load_cases();
    timeout_limit = total_flits * noc_cfg_pkg::NumPorts * 4 + 200;
    fork
      drive_input(0);
      drive_input(1);
      drive_input(2);
      drive_input(3);
    join_none
    wait (rst_n === 1'b1);
    // phases run one after another and all drivers start a phase on the same edge
    for (p = 1; p <= NumPhases; p++) begin
      @(posedge clk);
      cur_phase = p;
      while (recv_cnt[p] < phase_total[p]) @(negedge clk);
    end
    repeat (4) @(negedge clk);
    for (pair = 0; pair < NumPairs; pair++) begin
      if (exp_rd[pair] != exp_wr[pair]) begin
        misc_errs++;
        $display("%0d flits from input %0d never left output %0d",
                 exp_wr[pair] - exp_rd[pair], pair / noc_cfg_pkg::NumPorts,
                 pair % noc_cfg_pkg::NumPorts);
      end
    end
    $display("value errors %0d, other errors %0d", value_errs, misc_errs);
    if (value_errs + misc_errs == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* testbench/switch_cases.txt */
// columns: phase input dst payload last, all hex; payload top digit is the input
// phase 1 fairness, 2 parallel, 3 mixed traffic; a line of f ends the list
// phase 1: every input sends two single-flit packets to output 0
1 0 0 01000001 1
1 1 0 11000001 1
1 2 0 21000001 1
1 3 0 31000001 1
1 0 0 01000002 1
1 1 0 11000002 1
1 2 0 21000002 1
1 3 0 31000002 1
// phase 2: input k sends to output k
2 0 0 02000001 1
2 1 1 12000001 1
2 2 2 22000001 1
2 3 3 32000001 1
2 0 0 02000002 1
2 1 1 12000002 1
2 2 2 22000002 1
2 3 3 32000002 1
// phase 3: multi-flit packets competing for outputs 1 and 2
3 0 2 03a50001 0
3 0 2 03a50002 0
3 0 2 03a50003 1
3 0 1 03c30004 1
3 1 2 135a0001 0
3 1 2 135a0002 1
3 1 3 13960003 0
3 1 3 13960004 1
3 2 0 23e10001 1
3 2 2 237f0002 0
3 2 2 237f0003 1
3 3 1 33480001 0
3 3 1 33480002 0
3 3 1 33480003 1
3 3 2 33bd0004 1
f f f ffffffff f

/* project.f */
hw/noc_cfg_pkg.sv
hw/noc_flit_pkg.sv
hw/rr_arbiter.sv
hw/route_decode.sv
hw/output_port.sv
hw/grant_collect.sv
hw/noc_switch.sv
testbench/clk_gen.sv
testbench/tb_noc_switch.sv
